// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_radio_ctrl
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
src/settings_pkg.sv
src/atr_pkg.sv
src/cmd_port_if.sv
src/setting_reg.sv
src/settings_arbiter.sv
src/gpio_atr.sv
src/radio_ctrl_top.sv
dv/tb_radio_ctrl.sv

// ==== dv/tb_radio_ctrl.sv ====
//############################################################################
// Testbench for radio_ctrl_top with register model, LFSR stimulus,
// concurrent assertions, timeout and report
//############################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_radio_ctrl;

   localparam int LFSR_SEED      = 75533;
   localparam int TIMEOUT_CYCLES = 2000;
   localparam int WAIT_LIMIT     = 8;

   logic                    clk = 1'b0;
   logic                    rst, rx, tx;
   logic                    host_valid, host_ready, timed_valid, timed_ready;
   settings_pkg::set_addr_t host_addr, timed_addr;
   settings_pkg::set_data_t host_data, timed_data;
   atr_pkg::gpio_word_t     gpio_in, gpio_out, gpio_oe, gpio_readback;

   // Reference model of the arbiter and the five registers
   logic                    prio_m, wr_pend;
   settings_pkg::set_addr_t wr_addr;
   settings_pkg::set_data_t wr_data;
   atr_pkg::gpio_word_t     m_idle, m_rx, m_tx, m_fdx, m_ddr, exp_out;
   logic [1:0]              rx_p, tx_p;
   logic                    exp_host_grant, exp_timed_grant;

   logic [15:0] lfsr = 16'(LFSR_SEED);
   int          cycles = 0;
   int          errors = 0;
   int          tests = 0;

   radio_ctrl_top uut (.*);

   always #5 clk = ~clk;

   // Taps 16, 14, 13 and 11 with one step per bit taken
   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic settings_pkg::set_addr_t reg_addr(input settings_pkg::set_addr_t ofs);
      return settings_pkg::GPIO_BASE + ofs;
   endfunction

   function automatic void log_mismatch(input string msg);
      errors++;
      $display("ERR @ %0t: %s", $time, msg);
   endfunction

   task automatic report_test(input string name, input int start_errors);
      tests++;
      $display("%s: %0d errors", name, errors - start_errors);
   endtask

   task automatic tick(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // Holds one write on a port until accepted and returns the cycles spent waiting
   task automatic send_cmd(input logic on_timed, input settings_pkg::set_addr_t addr,
                           input settings_pkg::set_data_t data, output int waited);
      logic rdy;
      waited = 0;
      if (on_timed) begin
         timed_valid = 1'b1;
         timed_addr  = addr;
         timed_data  = data;
      end else begin
         host_valid = 1'b1;
         host_addr  = addr;
         host_data  = data;
      end
      #1;
      rdy = on_timed ? timed_ready : host_ready;
      while (!rdy && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         waited++;
         rdy = on_timed ? timed_ready : host_ready;
      end
      if (!rdy) begin
         $display("Handshake did not complete within %0d cycles", WAIT_LIMIT);
         errors++;
      end
      @(posedge clk);
      #1;
      if (on_timed) begin
         timed_valid = 1'b0;
      end else begin
         host_valid = 1'b0;
      end
   endtask

   // Host wins unless timed is also valid and holds the priority
   assign exp_host_grant  = host_valid && !(timed_valid && prio_m);
   assign exp_timed_grant = timed_valid && !(host_valid && !prio_m);

   always @(posedge clk) begin
      rx_p <= {rx_p[0], rx};
      tx_p <= {tx_p[0], tx};
      case ({tx_p[1], rx_p[1]})
         atr_pkg::ATR_IDLE: exp_out <= m_idle;
         atr_pkg::ATR_RX:   exp_out <= m_rx;
         atr_pkg::ATR_TX:   exp_out <= m_tx;
         default:           exp_out <= m_fdx;
      endcase
      if (rst) begin
         prio_m  <= 1'b0;
         wr_pend <= 1'b0;
         m_idle  <= atr_pkg::IDLE_RESET;
         m_ddr   <= atr_pkg::DDR_RESET;
      end else begin
         wr_pend <= exp_host_grant || exp_timed_grant;
         wr_addr <= exp_host_grant ? host_addr : timed_addr;
         wr_data <= exp_host_grant ? host_data : timed_data;
         if (host_valid && timed_valid) begin
            prio_m <= ~prio_m;
         end
         // Strobe cycle lands in the addressed register and nothing else
         if (wr_pend) begin
            case (wr_addr)
               reg_addr(settings_pkg::GPIO_IDLE_OFS): m_idle <= wr_data;
               reg_addr(settings_pkg::GPIO_RX_OFS):   m_rx   <= wr_data;
               reg_addr(settings_pkg::GPIO_TX_OFS):   m_tx   <= wr_data;
               reg_addr(settings_pkg::GPIO_FDX_OFS):  m_fdx  <= wr_data;
               reg_addr(settings_pkg::GPIO_DDR_OFS):  m_ddr  <= wr_data;
               default: ;
            endcase
         end
      end
   end

   assert property (@(posedge clk) disable iff (rst) host_ready == exp_host_grant)
      else log_mismatch("host_ready differs from the round-robin rule");
   assert property (@(posedge clk) disable iff (rst) timed_ready == exp_timed_grant)
      else log_mismatch("timed_ready differs from the round-robin rule");
   assert property (@(posedge clk) disable iff (rst)
                    $past(host_valid && !host_ready) |-> host_ready)
      else log_mismatch("host port waited more than one cycle");
   assert property (@(posedge clk) disable iff (rst)
                    $past(timed_valid && !timed_ready) |-> timed_ready)
      else log_mismatch("timed port waited more than one cycle");
   assert property (@(posedge clk) disable iff (rst) gpio_oe == m_ddr)
      else log_mismatch("gpio_oe differs from the direction register model");
   assert property (@(posedge clk) disable iff (rst) cycles > 4 |-> gpio_out == exp_out)
      else log_mismatch("gpio_out differs from the ATR word model");
   assert property (@(posedge clk) disable iff (rst)
                    cycles > 4 |-> gpio_readback == $past(gpio_in, 2))
      else log_mismatch("gpio_readback is not gpio_in from two edges earlier");

   task automatic probe_reset_defaults();
      int e0;
      e0 = errors;
      tick(4);
      assert (gpio_oe == '0) else log_mismatch("gpio_oe not zero after reset");
      assert (gpio_out == '0) else log_mismatch("gpio_out not zero under idle after reset");
      report_test("reset defaults", e0);
   endtask

   task automatic walk_atr_states();
      int                  e0;
      int                  w;
      atr_pkg::gpio_word_t words [4];
      logic [1:0]          s;
      e0 = errors;
      foreach (words[i]) words[i] = rand_bits(32);
      send_cmd(1'b0, reg_addr(settings_pkg::GPIO_IDLE_OFS), words[atr_pkg::ATR_IDLE], w);
      send_cmd(1'b0, reg_addr(settings_pkg::GPIO_RX_OFS), words[atr_pkg::ATR_RX], w);
      send_cmd(1'b0, reg_addr(settings_pkg::GPIO_TX_OFS), words[atr_pkg::ATR_TX], w);
      send_cmd(1'b0, reg_addr(settings_pkg::GPIO_FDX_OFS), words[atr_pkg::ATR_FDX], w);
      // Walk rx, tx, fdx and back to idle
      for (int i = 1; i <= 4; i++) begin
         s  = 2'(i);
         tx = s[1];
         rx = s[0];
         tick(3);
         assert (gpio_out == words[s]) else log_mismatch("gpio_out is not the ATR word");
      end
      report_test("ATR selection", e0);
   endtask

   task automatic load_ddr_mask();
      int                      e0;
      int                      w;
      settings_pkg::set_data_t d;
      e0 = errors;
      d  = rand_bits(32);
      send_cmd(1'b1, reg_addr(settings_pkg::GPIO_DDR_OFS), d, w);
      tick(2);
      assert (gpio_oe == d) else log_mismatch("gpio_oe is not the written direction word");
      report_test("direction mask", e0);
   endtask

   task automatic race_ports();
      int                      e0;
      int                      wh;
      int                      wt;
      settings_pkg::set_data_t dh, dt, second;
      settings_pkg::set_data_t burst [4];
      e0 = errors;
      dh = rand_bits(32);
      dt = rand_bits(32);
      fork
         send_cmd(1'b0, reg_addr(settings_pkg::GPIO_IDLE_OFS), dh, wh);
         send_cmd(1'b1, reg_addr(settings_pkg::GPIO_DDR_OFS), dt, wt);
      join
      assert (wh <= 1 && wt <= 1) else log_mismatch("handshake took more than two cycles");
      tick(3);
      assert (gpio_out == dh && gpio_oe == dt) else log_mismatch("a concurrent write was lost");
      // Same register twice so that both priority orders are seen
      repeat (2) begin
         dh     = rand_bits(32);
         dt     = rand_bits(32);
         second = prio_m ? dh : dt;
         fork
            send_cmd(1'b0, reg_addr(settings_pkg::GPIO_DDR_OFS), dh, wh);
            send_cmd(1'b1, reg_addr(settings_pkg::GPIO_DDR_OFS), dt, wt);
         join
         tick(2);
         assert (gpio_oe == second) else log_mismatch("same-address write order is wrong");
      end
      // Both ports stream two writes back to back and each loses one conflict
      foreach (burst[i]) burst[i] = rand_bits(32);
      fork
         begin
            send_cmd(1'b0, reg_addr(settings_pkg::GPIO_RX_OFS), burst[0], wh);
            send_cmd(1'b0, reg_addr(settings_pkg::GPIO_TX_OFS), burst[1], wh);
         end
         begin
            send_cmd(1'b1, reg_addr(settings_pkg::GPIO_FDX_OFS), burst[2], wt);
            send_cmd(1'b1, reg_addr(settings_pkg::GPIO_DDR_OFS), burst[3], wt);
         end
      join
      tick(2);
      assert (gpio_oe == burst[3]) else log_mismatch("streamed write was lost");
      report_test("arbitration", e0);
   endtask

   task automatic try_foreign_addrs();
      int                      e0;
      int                      w;
      settings_pkg::set_addr_t bad [5];
      atr_pkg::gpio_word_t     out0, oe0;
      e0   = errors;
      bad  = '{8'h00, 8'h0f, settings_pkg::GPIO_BASE + 8'd5, 8'h20, 8'hff};
      out0 = gpio_out;
      oe0  = gpio_oe;
      foreach (bad[i]) send_cmd(1'(i % 2), bad[i], rand_bits(32), w);
      tick(3);
      assert (gpio_out == out0 && gpio_oe == oe0) else log_mismatch("foreign address took effect");
      report_test("address filter", e0);
   endtask

   task automatic stream_gpio_in();
      int e0;
      e0 = errors;
      repeat (24) begin
         gpio_in = rand_bits(32);
         tick(1);
      end
      tick(2);
      report_test("readback", e0);
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Run stopped after %0d cycles without finishing the tests", cycles);
         $display("TB FAILED");
         $finish;
      end
   end

   initial begin
      rst         = 1'b1;
      rx          = 1'b0;
      tx          = 1'b0;
      host_valid  = 1'b0;
      host_addr   = '0;
      host_data   = '0;
      timed_valid = 1'b0;
      timed_addr  = '0;
      timed_data  = '0;
      gpio_in     = '0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      probe_reset_defaults();
      walk_atr_states();
      load_ddr_mask();
      race_ports();
      try_foreign_addrs();
      stream_gpio_in();
      $display("Tests run: %0d, errors: %0d", tests, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/atr_pkg.sv ====
//##########################################################################
// Pin width, pin word type, ATR state encoding, delay and reset constants
//##########################################################################
`default_nettype none

package atr_pkg;

   localparam int GPIO_W = 32;

   typedef logic [GPIO_W-1:0] gpio_word_t;

   // Encoded as {tx, rx}
   typedef enum logic [1:0] {
      ATR_IDLE = 2'b00,
      ATR_RX   = 2'b01,
      ATR_TX   = 2'b10,
      ATR_FDX  = 2'b11
   } atr_state_t;

   // Stages on rx/tx before they pick the output word
   localparam int STATE_DELAY = 2;

   localparam gpio_word_t IDLE_RESET = '0;
   localparam gpio_word_t DDR_RESET  = '0;

endpackage

`default_nettype wire

// ==== src/cmd_port_if.sv ====
//##########################################################################
// Valid/ready command port carrying one settings write
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

interface cmd_port_if;

   logic                  valid;
   logic                  ready;
   settings_pkg::set_addr_t addr;
   settings_pkg::set_data_t data;

   // Command source, holds addr/data until accepted
   modport source (
      output valid,
      output addr,
      output data,
      input  ready
   );

   modport arbiter (
      input  valid,
      input  addr,
      input  data,
      output ready
   );

endinterface

`default_nettype wire

// ==== src/gpio_atr.sv ====
//##########################################################################
// ATR GPIO block: setting registers, rx/tx delay, output select,
// direction mask and input synchronizer
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module gpio_atr (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    set_stb,
   input  settings_pkg::set_addr_t set_addr,
   input  settings_pkg::set_data_t set_data,
   input  logic                    rx,
   input  logic                    tx,
   input  atr_pkg::gpio_word_t     gpio_in,
   output atr_pkg::gpio_word_t     gpio_out,
   output atr_pkg::gpio_word_t     gpio_oe,
   output atr_pkg::gpio_word_t     gpio_readback
);

   atr_pkg::gpio_word_t word_idle;
   atr_pkg::gpio_word_t word_rx;
   atr_pkg::gpio_word_t word_tx;
   atr_pkg::gpio_word_t word_fdx;
   atr_pkg::gpio_word_t ddr;

   logic [atr_pkg::STATE_DELAY-1:0] rx_d;
   logic [atr_pkg::STATE_DELAY-1:0] tx_d;
   atr_pkg::atr_state_t             state;
   atr_pkg::gpio_word_t             gpio_in_q;

   setting_reg #(
      .REG_ADDR  (settings_pkg::GPIO_BASE + settings_pkg::GPIO_IDLE_OFS),
      .RESET_VAL (atr_pkg::IDLE_RESET)
   ) reg_idle (
      .clk, .rst, .set_stb, .set_addr, .set_data, .value(word_idle)
   );

   setting_reg #(
      .REG_ADDR (settings_pkg::GPIO_BASE + settings_pkg::GPIO_RX_OFS)
   ) reg_rx (
      .clk, .rst, .set_stb, .set_addr, .set_data, .value(word_rx)
   );

   setting_reg #(
      .REG_ADDR (settings_pkg::GPIO_BASE + settings_pkg::GPIO_TX_OFS)
   ) reg_tx (
      .clk, .rst, .set_stb, .set_addr, .set_data, .value(word_tx)
   );

   setting_reg #(
      .REG_ADDR (settings_pkg::GPIO_BASE + settings_pkg::GPIO_FDX_OFS)
   ) reg_fdx (
      .clk, .rst, .set_stb, .set_addr, .set_data, .value(word_fdx)
   );

   setting_reg #(
      .REG_ADDR  (settings_pkg::GPIO_BASE + settings_pkg::GPIO_DDR_OFS),
      .RESET_VAL (atr_pkg::DDR_RESET)
   ) reg_ddr (
      .clk, .rst, .set_stb, .set_addr, .set_data, .value(ddr)
   );

   // Delay stages ease timing and fanout toward the pads
   always_ff @(posedge clk) begin
      rx_d <= {rx_d[atr_pkg::STATE_DELAY-2:0], rx};
      tx_d <= {tx_d[atr_pkg::STATE_DELAY-2:0], tx};
   end

   assign state = atr_pkg::atr_state_t'({tx_d[atr_pkg::STATE_DELAY-1],
                                         rx_d[atr_pkg::STATE_DELAY-1]});

   always_ff @(posedge clk) begin
      case (state)
         atr_pkg::ATR_IDLE: gpio_out <= word_idle;
         atr_pkg::ATR_RX:   gpio_out <= word_rx;
         atr_pkg::ATR_TX:   gpio_out <= word_tx;
         default:           gpio_out <= word_fdx;
      endcase
   end

   // Pad buffer outside the design applies this per pin
   assign gpio_oe = ddr;

   // First flop at the pad, second in the core
   always_ff @(posedge clk) begin
      gpio_in_q     <= gpio_in;
      gpio_readback <= gpio_in_q;
   end

endmodule

`default_nettype wire

// ==== src/radio_ctrl_top.sv ====
//##########################################################################
// Radio front-end control top: command ports, settings arbiter, ATR GPIO
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    host_valid,
   output logic                    host_ready,
   input  settings_pkg::set_addr_t host_addr,
   input  settings_pkg::set_data_t host_data,
   input  logic                    timed_valid,
   output logic                    timed_ready,
   input  settings_pkg::set_addr_t timed_addr,
   input  settings_pkg::set_data_t timed_data,
   input  logic                    rx,
   input  logic                    tx,
   input  atr_pkg::gpio_word_t     gpio_in,
   output atr_pkg::gpio_word_t     gpio_out,
   output atr_pkg::gpio_word_t     gpio_oe,
   output atr_pkg::gpio_word_t     gpio_readback
);

   cmd_port_if host_if ();
   cmd_port_if timed_if ();

   logic                    set_stb;
   settings_pkg::set_addr_t set_addr;
   settings_pkg::set_data_t set_data;

   // Host processor port
   assign host_if.valid = host_valid;
   assign host_if.addr  = host_addr;
   assign host_if.data  = host_data;
   assign host_ready    = host_if.ready;

   // Timed command port
   assign timed_if.valid = timed_valid;
   assign timed_if.addr  = timed_addr;
   assign timed_if.data  = timed_data;
   assign timed_ready    = timed_if.ready;

   settings_arbiter u_arbiter (
      .clk      (clk),
      .rst      (rst),
      .host     (host_if.arbiter),
      .timed    (timed_if.arbiter),
      .set_stb  (set_stb),
      .set_addr (set_addr),
      .set_data (set_data)
   );

   gpio_atr u_gpio_atr (
      .clk           (clk),
      .rst           (rst),
      .set_stb       (set_stb),
      .set_addr      (set_addr),
      .set_data      (set_data),
      .rx            (rx),
      .tx            (tx),
      .gpio_in       (gpio_in),
      .gpio_out      (gpio_out),
      .gpio_oe       (gpio_oe),
      .gpio_readback (gpio_readback)
   );

endmodule

`default_nettype wire

// ==== src/setting_reg.sv ====
//##########################################################################
// Single addressed configuration register with reset value
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module setting_reg #(
   parameter settings_pkg::set_addr_t REG_ADDR  = '0,
   parameter atr_pkg::gpio_word_t     RESET_VAL = '0
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    set_stb,
   input  settings_pkg::set_addr_t set_addr,
   input  settings_pkg::set_data_t set_data,
   output atr_pkg::gpio_word_t     value
);

   always_ff @(posedge clk) begin
      if (rst) begin
         value <= RESET_VAL;
      end else if (set_stb && (set_addr == REG_ADDR)) begin
         // Only the pin-wide low part of the bus word is kept
         value <= set_data[atr_pkg::GPIO_W-1:0];
      end
   end

endmodule

`default_nettype wire

// ==== src/settings_arbiter.sv ====
//##########################################################################
// Round-robin arbiter merging host and timed command ports
// onto one registered settings bus
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module settings_arbiter (
   input  logic                    clk,
   input  logic                    rst,
   cmd_port_if.arbiter             host,
   cmd_port_if.arbiter             timed,
   output logic                    set_stb,
   output settings_pkg::set_addr_t set_addr,
   output settings_pkg::set_data_t set_data
);

   // Low gives the host port the win in a conflict, high the timed port
   logic prio;
   logic grant_host;
   logic grant_timed;
   logic conflict;

   assign conflict    = host.valid & timed.valid;
   assign grant_host  = host.valid & (~timed.valid | ~prio);
   assign grant_timed = timed.valid & (~host.valid | prio);

   assign host.ready  = grant_host;
   assign timed.ready = grant_timed;

   always_ff @(posedge clk) begin
      if (rst) begin
         prio <= 1'b0;
      end else if (conflict) begin
         prio <= ~prio;
      end
   end

   // One strobe per accepted write, low in idle cycles
   always_ff @(posedge clk) begin
      if (rst) begin
         set_stb <= 1'b0;
      end else begin
         set_stb <= grant_host | grant_timed;
      end
   end

   always_ff @(posedge clk) begin
      if (grant_host) begin
         set_addr <= host.addr;
         set_data <= host.data;
      end else if (grant_timed) begin
         set_addr <= timed.addr;
         set_data <= timed.data;
      end
   end

endmodule

`default_nettype wire

// ==== src/settings_pkg.sv ====
//##########################################################################
// Settings bus widths and address/data types
// GPIO block register address map
//##########################################################################
`default_nettype none

package settings_pkg;

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef logic [SET_ADDR_W-1:0] set_addr_t;
   typedef logic [SET_DATA_W-1:0] set_data_t;

   // Start of the GPIO register window
   localparam set_addr_t GPIO_BASE = 8'h10;

   // Offsets within the GPIO window
   localparam set_addr_t GPIO_IDLE_OFS = 8'd0;
   localparam set_addr_t GPIO_RX_OFS   = 8'd1;
   localparam set_addr_t GPIO_TX_OFS   = 8'd2;
   localparam set_addr_t GPIO_FDX_OFS  = 8'd3;
   localparam set_addr_t GPIO_DDR_OFS  = 8'd4;

endpackage

`default_nettype wire
